// File: ifm_pkg.sv
package ifm_pkg;

	////////////////////////////////////////
	// Sizes
	////////////////////////////////////////

	// Bits per sparsemap window
	localparam int PREFIX_SUM_SIZE = 8;
	// Activations per sub-chunk
	localparam int CHUNK_SIZE = 64;
	localparam int WIN_NUM = CHUNK_SIZE / PREFIX_SUM_SIZE;

	localparam int WIN_POS_W = $clog2(PREFIX_SUM_SIZE);
	// Counts run 0 to PREFIX_SUM_SIZE inclusive
	localparam int PREFIX_CNT_W = $clog2(PREFIX_SUM_SIZE) + 1;
	localparam int CHUNK_IDX_W = $clog2(CHUNK_SIZE);
	localparam int CHUNK_ADDR_W = CHUNK_IDX_W + 1;
	localparam int WIN_IDX_W = $clog2(WIN_NUM);
	localparam int IFM_DATA_W = 8;

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	typedef logic [PREFIX_SUM_SIZE-1:0] sparsemap_t;
	typedef logic [WIN_POS_W-1:0] win_pos_t;
	typedef logic [PREFIX_CNT_W-1:0] prefix_cnt_t;
	typedef logic [CHUNK_ADDR_W-1:0] chunk_addr_t;
	typedef logic [WIN_IDX_W-1:0] win_idx_t;
	typedef logic [IFM_DATA_W-1:0] ifm_data_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_SCAN,
		ST_DONE
	} ctrl_state_t;

	// Buffer write, sel_map picks sparsemap over data store
	typedef struct packed {
		logic en;
		logic sel_map;
		chunk_addr_t addr;
		ifm_data_t data;
	} ifm_wr_t;

	typedef struct packed {
		ifm_data_t data;
		win_idx_t win;
		win_pos_t pos;
		logic last;
	} ifm_item_t;

endpackage

// File: prefix_sum.sv
module prefix_sum
	import ifm_pkg::*;
(
	 input sparsemap_t in_i
	,output prefix_cnt_t out_o [PREFIX_SUM_SIZE]
	,output prefix_cnt_t total_o
);

	prefix_cnt_t acc_w;

	// Exclusive running count, out_o[i] sees bits below i only
	always_comb begin
		acc_w = '0;
		for (int i = 0; i < PREFIX_SUM_SIZE; i++) begin
			out_o[i] = acc_w;
			acc_w = acc_w + prefix_cnt_t'(in_i[i]);
		end
	end

	// Full window count
	assign total_o = acc_w;

endmodule

// File: pri_enc_scan.sv
module pri_enc_scan
	import ifm_pkg::*;
(
	 input rst_i
	,input gated_clk_0_w

	,input load_i
	,input sparsemap_t map_i
	,input scan_i

	,output logic match_valid_o
	,output win_pos_t match_addr_o
	,output logic pri_enc_end_o
);

	sparsemap_t mask_r;
	sparsemap_t lowest_w;

	// Isolate lowest set bit
	assign lowest_w = mask_r & (~mask_r + 1'b1);

	always_ff @(posedge gated_clk_0_w) begin
		if (rst_i) begin
			mask_r <= '0;
		end
		else if (load_i) begin
			mask_r <= map_i;
		end
		else if (scan_i) begin
			// Retire the bit reported this cycle
			mask_r <= mask_r & ~lowest_w;
		end
	end

	// Lowest index wins, so walk downwards
	always_comb begin
		match_addr_o = '0;
		for (int i = PREFIX_SUM_SIZE - 1; i >= 0; i--) begin
			if (mask_r[i]) begin
				match_addr_o = win_pos_t'(i);
			end
		end
	end

	// Mask only holds bits between load and the last scan cycle
	assign match_valid_o = |mask_r;

	// Zero or one bit left ends the window
	assign pri_enc_end_o = scan_i && ((mask_r & (mask_r - 1'b1)) == '0);

	// Leftover bits outside a scan mean the FSM left the window early
	a_match_in_scan: assert property (
		@(posedge gated_clk_0_w) disable iff (rst_i)
		match_valid_o |-> scan_i
	);

endmodule

// File: ifm_input_sel.sv
module ifm_input_sel
	import ifm_pkg::*;
(
	 input rst_i
	,input gated_clk_0_w

	,input win_pos_t pri_enc_match_addr_i
	,input pri_enc_end_i
	,input sub_chunk_start_i

	,input sparsemap_t rd_sparsemap_i
	,output chunk_addr_t rd_addr_o
);

	prefix_cnt_t prefix_sum_out_w [PREFIX_SUM_SIZE];
	prefix_cnt_t prefix_total_w;
	chunk_addr_t rd_dat_base_addr_r;

	prefix_sum u_prefix_sum (
		 .in_i(rd_sparsemap_i)
		,.out_o(prefix_sum_out_w)
		,.total_o(prefix_total_w)
	);

	////////////////////////////////////////
	// Base address
	////////////////////////////////////////

	// Channel padding, every sub-chunk begins at address zero
	always_ff @(posedge gated_clk_0_w) begin
		if (rst_i) begin
			rd_dat_base_addr_r <= '0;
		end
		else if (sub_chunk_start_i) begin
			rd_dat_base_addr_r <= '0;
		end
		else if (pri_enc_end_i) begin
			rd_dat_base_addr_r <= rd_dat_base_addr_r + chunk_addr_t'(prefix_total_w);
		end
	end

	// Offset of this match inside the packed data
	assign rd_addr_o = rd_dat_base_addr_r + chunk_addr_t'(prefix_sum_out_w[pri_enc_match_addr_i]);

	// A sub-chunk never packs more than CHUNK_SIZE values
	a_base_in_range: assert property (
		@(posedge gated_clk_0_w) disable iff (rst_i)
		rd_dat_base_addr_r <= chunk_addr_t'(CHUNK_SIZE)
	);

endmodule

// File: win_counter.sv
module win_counter
	import ifm_pkg::*;
(
	 input rst_i
	,input gated_clk_0_w

	,input clr_i
	,input step_i

	,output win_idx_t win_idx_o
	,output logic last_win_o
);

	win_idx_t win_idx_r;

	// Clear takes priority over step
	always_ff @(posedge gated_clk_0_w) begin
		if (rst_i) begin
			win_idx_r <= '0;
		end
		else if (clr_i) begin
			win_idx_r <= '0;
		end
		else if (step_i) begin
			win_idx_r <= win_idx_r + 1'b1;
		end
	end

	assign win_idx_o = win_idx_r;

	// Final window of the sub-chunk
	assign last_win_o = (win_idx_r == win_idx_t'(WIN_NUM - 1));

endmodule

// File: chunk_ctrl_fsm.sv
module chunk_ctrl_fsm
	import ifm_pkg::*;
(
	 input rst_i
	,input gated_clk_0_w

	,input start_i
	,input pri_enc_end_i
	,input last_win_i

	,output logic busy_o
	,output logic sub_chunk_start_o
	,output logic win_load_o
	,output logic scan_o
	,output logic win_clr_o
	,output logic win_step_o
	,output logic chunk_end_o
);

	ctrl_state_t state_r;
	ctrl_state_t state_nxt_w;
	logic win_end_w;

	////////////////////////////////////////
	// State register
	////////////////////////////////////////

	always_ff @(posedge gated_clk_0_w) begin
		if (rst_i) begin
			state_r <= ST_IDLE;
		end
		else begin
			state_r <= state_nxt_w;
		end
	end

	// Scan has finished the current window
	assign win_end_w = (state_r == ST_SCAN) && pri_enc_end_i;

	always_comb begin
		state_nxt_w = state_r;
		case (state_r)
			ST_IDLE: begin
				if (start_i) begin
					state_nxt_w = ST_LOAD;
				end
			end
			// Map word arrives during this single cycle
			ST_LOAD: begin
				state_nxt_w = ST_SCAN;
			end
			ST_SCAN: begin
				if (pri_enc_end_i) begin
					state_nxt_w = last_win_i ? ST_DONE : ST_LOAD;
				end
			end
			ST_DONE: begin
				state_nxt_w = ST_IDLE;
			end
			default: begin
				state_nxt_w = ST_IDLE;
			end
		endcase
	end

	////////////////////////////////////////
	// Outputs
	////////////////////////////////////////

	assign busy_o = (state_r != ST_IDLE);
	assign sub_chunk_start_o = (state_r == ST_IDLE) && start_i;
	// Window index restarts with the sub-chunk
	assign win_clr_o = sub_chunk_start_o;
	assign win_load_o = (state_r == ST_LOAD);
	assign scan_o = (state_r == ST_SCAN);
	assign win_step_o = win_end_w && !last_win_i;
	assign chunk_end_o = win_end_w && last_win_i;

	a_state_legal: assert property (
		@(posedge gated_clk_0_w) disable iff (rst_i)
		state_r inside {ST_IDLE, ST_LOAD, ST_SCAN, ST_DONE}
	);

endmodule

// File: ifm_chunk_buf.sv
module ifm_chunk_buf
	import ifm_pkg::*;
(
	 input gated_clk_0_w

	,input ifm_wr_t wr_i

	,input win_idx_t map_rd_idx_i
	,output sparsemap_t map_o

	,input chunk_addr_t data_rd_addr_i
	,output ifm_data_t data_o
);

	sparsemap_t map_mem [WIN_NUM];
	ifm_data_t data_mem [CHUNK_SIZE];

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	always_ff @(posedge gated_clk_0_w) begin
		if (wr_i.en) begin
			if (wr_i.sel_map) begin
				map_mem[wr_i.addr[WIN_IDX_W-1:0]] <= sparsemap_t'(wr_i.data);
			end
			else begin
				data_mem[wr_i.addr[CHUNK_IDX_W-1:0]] <= wr_i.data;
			end
		end
	end

	////////////////////////////////////////
	// Read ports
	////////////////////////////////////////

	// One cycle from index to map word
	always_ff @(posedge gated_clk_0_w) begin
		map_o <= map_mem[map_rd_idx_i];
	end

	// Top address bit only matters for the range check upstream
	always_ff @(posedge gated_clk_0_w) begin
		data_o <= data_mem[data_rd_addr_i[CHUNK_IDX_W-1:0]];
	end

endmodule

// File: ifm_subchunk_top.sv
module ifm_subchunk_top
	import ifm_pkg::*;
(
	 input rst_i
	,input gated_clk_0_w
	,input start_i

	,input ifm_wr_t wr_i

	,output logic busy_o
	,output logic out_valid_o
	,output ifm_item_t out_item_o
	,output logic done_o
);

	logic sub_chunk_start_w;
	logic win_load_w;
	logic scan_w;
	logic win_clr_w;
	logic win_step_w;
	logic chunk_end_w;
	logic last_win_w;
	win_idx_t win_idx_w;
	win_idx_t map_rd_idx_w;
	sparsemap_t map_rd_w;
	sparsemap_t win_map_r;
	logic match_valid_w;
	win_pos_t match_addr_w;
	logic pri_enc_end_w;
	chunk_addr_t rd_addr_w;
	ifm_data_t rd_data_w;

	// Item side channel, one stage to line up with the data read
	logic out_valid_r;
	win_idx_t item_win_r;
	win_pos_t item_pos_r;
	logic item_last_r;
	logic done_r;

	chunk_ctrl_fsm u_ctrl (
		 .rst_i(rst_i)
		,.gated_clk_0_w(gated_clk_0_w)
		,.start_i(start_i)
		,.pri_enc_end_i(pri_enc_end_w)
		,.last_win_i(last_win_w)
		,.busy_o(busy_o)
		,.sub_chunk_start_o(sub_chunk_start_w)
		,.win_load_o(win_load_w)
		,.scan_o(scan_w)
		,.win_clr_o(win_clr_w)
		,.win_step_o(win_step_w)
		,.chunk_end_o(chunk_end_w)
	);

	win_counter u_win_cnt (
		 .rst_i(rst_i)
		,.gated_clk_0_w(gated_clk_0_w)
		,.clr_i(win_clr_w)
		,.step_i(win_step_w)
		,.win_idx_o(win_idx_w)
		,.last_win_o(last_win_w)
	);

	// Issue the map read for the window about to load
	assign map_rd_idx_w = win_clr_w ? '0 : (win_step_w ? win_idx_w + 1'b1 : win_idx_w);

	ifm_chunk_buf u_buf (
		 .gated_clk_0_w(gated_clk_0_w)
		,.wr_i(wr_i)
		,.map_rd_idx_i(map_rd_idx_w)
		,.map_o(map_rd_w)
		,.data_rd_addr_i(rd_addr_w)
		,.data_o(rd_data_w)
	);

	pri_enc_scan u_pri_enc (
		 .rst_i(rst_i)
		,.gated_clk_0_w(gated_clk_0_w)
		,.load_i(win_load_w)
		,.map_i(map_rd_w)
		,.scan_i(scan_w)
		,.match_valid_o(match_valid_w)
		,.match_addr_o(match_addr_w)
		,.pri_enc_end_o(pri_enc_end_w)
	);

	// Window word held for the prefix sums during scan
	always_ff @(posedge gated_clk_0_w) begin
		if (win_load_w) begin
			win_map_r <= map_rd_w;
		end
	end

	ifm_input_sel u_input_sel (
		 .rst_i(rst_i)
		,.gated_clk_0_w(gated_clk_0_w)
		,.pri_enc_match_addr_i(match_addr_w)
		,.pri_enc_end_i(pri_enc_end_w)
		,.sub_chunk_start_i(sub_chunk_start_w)
		,.rd_sparsemap_i(win_map_r)
		,.rd_addr_o(rd_addr_w)
	);

	////////////////////////////////////////
	// Output stage
	////////////////////////////////////////

	always_ff @(posedge gated_clk_0_w) begin
		if (rst_i) begin
			out_valid_r <= 1'b0;
			done_r <= 1'b0;
		end
		else begin
			out_valid_r <= match_valid_w;
			// Empty final window ends at once, else wait for the last item
			done_r <= (chunk_end_w && !match_valid_w) || (out_valid_r && item_last_r);
		end
	end

	always_ff @(posedge gated_clk_0_w) begin
		item_win_r <= win_idx_w;
		item_pos_r <= match_addr_w;
		item_last_r <= chunk_end_w && match_valid_w;
	end

	assign out_valid_o = out_valid_r;
	assign out_item_o.data = rd_data_w;
	assign out_item_o.win = item_win_r;
	assign out_item_o.pos = item_pos_r;
	assign out_item_o.last = item_last_r;
	assign done_o = done_r;

	// Buffers must stay still while a sub-chunk is read
	a_no_wr_busy: assert property (
		@(posedge gated_clk_0_w) disable iff (rst_i)
		wr_i.en |-> !busy_o
	);

endmodule

// File: tb_ifm_subchunk.sv
module tb_ifm_subchunk
	import ifm_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_PATTERNS = 5;
	// Map words for windows 0 to WIN_NUM-1, then the item count
	localparam int PAT_COLS = WIN_NUM + 1;
	// Last pattern runs a second time straight after the first
	localparam int NUM_RUNS = NUM_PATTERNS + 1;
	localparam int RESET_CYCLES = 8;
	localparam int CYCLE_LIMIT = 20 * WIN_NUM * NUM_RUNS
		+ NUM_PATTERNS * (WIN_NUM + CHUNK_SIZE) + RESET_CYCLES + 200;

	logic gated_clk_0_w;
	logic rst_i;
	logic start_i;
	ifm_wr_t wr_i;
	logic busy_o;
	logic out_valid_o;
	ifm_item_t out_item_o;
	logic done_o;

	logic [7:0] pat_mem [NUM_PATTERNS * PAT_COLS];
	string pat_names [NUM_PATTERNS];
	ifm_data_t data_vals [CHUNK_SIZE];
	ifm_item_t exp_q [$];
	logic [31:0] lfsr_state;
	int cycle_cnt;
	int tests_run;
	int tests_failed;

	ifm_subchunk_top UUT (
		 .rst_i(rst_i)
		,.gated_clk_0_w(gated_clk_0_w)
		,.start_i(start_i)
		,.wr_i(wr_i)
		,.busy_o(busy_o)
		,.out_valid_o(out_valid_o)
		,.out_item_o(out_item_o)
		,.done_o(done_o)
	);

	initial begin
		gated_clk_0_w = 1'b0;
		forever begin
			#50 gated_clk_0_w = ~gated_clk_0_w;
		end
	end

	// Watchdog
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge gated_clk_0_w);
			cycle_cnt = cycle_cnt + 1;
		end
		$display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
		$display("Result: FAILED");
		$finish;
	end

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic fb;
		fb = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], fb};
	endfunction

	task automatic take_random_byte(output ifm_data_t value);
		value = '0;
		for (int b = 0; b < IFM_DATA_W; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[IFM_DATA_W-2:0], lfsr_state[0]};
		end
	endtask

	function automatic sparsemap_t map_word(input int pat, input int win);
		return sparsemap_t'(pat_mem[pat * PAT_COLS + win]);
	endfunction

	function automatic int pattern_count(input int pat);
		return int'(pat_mem[pat * PAT_COLS + WIN_NUM]);
	endfunction

	task automatic write_word(input logic sel_map, input int addr, input ifm_data_t data);
		@(posedge gated_clk_0_w);
		wr_i <= '{en: 1'b1, sel_map: sel_map, addr: chunk_addr_t'(addr), data: data};
	endtask

	// Map words first, then the packed nonzero values
	task automatic load_buffers(input int pat);
		int total;
		total = 0;
		for (int w = 0; w < WIN_NUM; w++) begin
			write_word(1'b1, w, ifm_data_t'(map_word(pat, w)));
			total = total + $countones(map_word(pat, w));
		end
		for (int k = 0; k < total; k++) begin
			take_random_byte(data_vals[k]);
			write_word(1'b0, k, data_vals[k]);
		end
		@(posedge gated_clk_0_w);
		wr_i <= '0;
	endtask

	// Set bits in window order then position order, k-th bit gets k-th value
	task automatic build_expected(input int pat);
		sparsemap_t word;
		ifm_item_t item;
		int k;
		exp_q.delete();
		k = 0;
		for (int w = 0; w < WIN_NUM; w++) begin
			word = map_word(pat, w);
			for (int p = 0; p < PREFIX_SUM_SIZE; p++) begin
				if (word[p]) begin
					item.data = data_vals[k];
					item.win = win_idx_t'(w);
					item.pos = win_pos_t'(p);
					// Only the top set bit of the final window ends the chunk
					item.last = (w == WIN_NUM - 1) && ((word >> (p + 1)) == '0);
					exp_q.push_back(item);
					k = k + 1;
				end
			end
		end
	endtask

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	task automatic run_subchunk(input int pat, input string label);
		ifm_item_t exp_item;
		int test_no;
		int got;
		int errs;
		bit done_seen;
		bit last_prev;
		test_no = tests_run + 1;
		build_expected(pat);
		errs = 0;
		got = 0;
		done_seen = 1'b0;
		last_prev = 1'b0;
		@(posedge gated_clk_0_w);
		start_i <= 1'b1;
		@(posedge gated_clk_0_w);
		start_i <= 1'b0;
		@(negedge gated_clk_0_w);
		if (busy_o !== 1'b1) begin
			$display("FAILED test %0d busy_o: got %h expected %h", test_no, busy_o, 1'b1);
			errs = errs + 1;
		end
		while (!done_seen) begin
			// Done follows the item flagged last by one cycle
			if (last_prev && (done_o !== 1'b1)) begin
				$display("FAILED test %0d done_o: got %h expected %h", test_no, done_o, 1'b1);
				errs = errs + 1;
			end
			last_prev = out_valid_o && out_item_o.last;
			if (out_valid_o) begin
				got = got + 1;
				if (exp_q.size() == 0) begin
					$display("Test %0d: item arrived after all expected items", test_no);
					errs = errs + 1;
				end
				else begin
					exp_item = exp_q.pop_front();
					if (out_item_o.data !== exp_item.data) begin
						$display("FAILED test %0d item %0d out_item_o.data: got %h expected %h",
							test_no, got, out_item_o.data, exp_item.data);
						errs = errs + 1;
					end
					if (out_item_o.win !== exp_item.win) begin
						$display("FAILED test %0d item %0d out_item_o.win: got %h expected %h",
							test_no, got, out_item_o.win, exp_item.win);
						errs = errs + 1;
					end
					if (out_item_o.pos !== exp_item.pos) begin
						$display("FAILED test %0d item %0d out_item_o.pos: got %h expected %h",
							test_no, got, out_item_o.pos, exp_item.pos);
						errs = errs + 1;
					end
					if (out_item_o.last !== exp_item.last) begin
						$display("FAILED test %0d item %0d out_item_o.last: got %h expected %h",
							test_no, got, out_item_o.last, exp_item.last);
						errs = errs + 1;
					end
				end
			end
			if (done_o) begin
				done_seen = 1'b1;
			end
			else begin
				@(negedge gated_clk_0_w);
			end
		end
		if (got != pattern_count(pat)) begin
			$display("FAILED test %0d item count: got %h expected %h",
				test_no, got, pattern_count(pat));
			errs = errs + 1;
		end
		if (exp_q.size() != 0) begin
			$display("Test %0d: done_o came with %0d items still missing", test_no, exp_q.size());
			errs = errs + 1;
		end
		// Done is a single pulse and the block is idle again
		@(negedge gated_clk_0_w);
		if (done_o !== 1'b0) begin
			$display("FAILED test %0d done_o: got %h expected %h", test_no, done_o, 1'b0);
			errs = errs + 1;
		end
		if (busy_o !== 1'b0) begin
			$display("FAILED test %0d busy_o: got %h expected %h", test_no, busy_o, 1'b0);
			errs = errs + 1;
		end
		if (out_valid_o !== 1'b0) begin
			$display("FAILED test %0d out_valid_o: got %h expected %h",
				test_no, out_valid_o, 1'b0);
			errs = errs + 1;
		end
		tests_run = tests_run + 1;
		if (errs == 0) begin
			$display("Test %0d %s: ok, %0d items", test_no, label, got);
		end
		else begin
			tests_failed = tests_failed + 1;
			$display("Test %0d %s: %0d errors", test_no, label, errs);
		end
	endtask

	task automatic check_reset_state();
		int errs;
		errs = 0;
		@(negedge gated_clk_0_w);
		if (busy_o !== 1'b0) begin
			$display("FAILED test 1 busy_o: got %h expected %h", busy_o, 1'b0);
			errs = errs + 1;
		end
		if (out_valid_o !== 1'b0) begin
			$display("FAILED test 1 out_valid_o: got %h expected %h", out_valid_o, 1'b0);
			errs = errs + 1;
		end
		if (done_o !== 1'b0) begin
			$display("FAILED test 1 done_o: got %h expected %h", done_o, 1'b0);
			errs = errs + 1;
		end
		tests_run = tests_run + 1;
		if (errs == 0) begin
			$display("Test 1 reset state: ok");
		end
		else begin
			tests_failed = tests_failed + 1;
			$display("Test 1 reset state: %0d errors", errs);
		end
	endtask

	initial begin : main_seq
		rst_i = 1'b1;
		start_i = 1'b0;
		wr_i = '0;
		lfsr_state = 32'h77ce;
		tests_run = 0;
		tests_failed = 0;
		pat_names[0] = "mixed windows";
		pat_names[1] = "full and empty windows";
		pat_names[2] = "empty final window";
		pat_names[3] = "all-zero sub-chunk";
		pat_names[4] = "dense windows";
		$readmemh("ifm_patterns.txt", pat_mem);
		repeat (RESET_CYCLES) @(posedge gated_clk_0_w);
		rst_i <= 1'b0;
		check_reset_state();
		// No reset between runs, so each start must clear the base address
		for (int t = 0; t < NUM_PATTERNS; t++) begin
			load_buffers(t);
			run_subchunk(t, pat_names[t]);
		end
		run_subchunk(NUM_PATTERNS - 1, "back-to-back rerun");
		$display("Summary: %0d tests, %0d passed, %0d failed",
			tests_run, tests_run - tests_failed, tests_failed);
		if (tests_failed == 0) begin
			$display("Result: PASSED");
		end
		else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: ifm_patterns.txt
// One sub-chunk per line: sparsemap words for windows 0 to 7 in hex,
// then the expected item count (set bits on the line) in hex
// Mixed windows with one empty window in the middle
a5 3c 01 80 ff 00 12 c3 18
// Full and empty windows, final window full
ff 00 ff 00 00 81 00 ff 1a
// Items only in early windows, final window empty
00 ff 00 00 00 00 40 00 09
// No set bits at all
00 00 00 00 00 00 00 00 00
// Dense windows, also rerun back to back
0f f0 33 cc 55 aa 01 80 1a

// File: verilog.f
ifm_pkg.sv
prefix_sum.sv
pri_enc_scan.sv
ifm_input_sel.sv
win_counter.sv
chunk_ctrl_fsm.sv
ifm_chunk_buf.sv
ifm_subchunk_top.sv
tb_ifm_subchunk.sv
